// File: all.f
+incdir+hw
hw/rf_pkg.sv
hw/rf_if.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/operand_stage.sv
hw/rf_top.sv
verification/rf_assertions.sv
verification/rf_checker.sv
verification/rf_tb.sv

// File: hw/csr_file.sv
`include "rf_consts.svh"

module csr_file (
  input  logic          clk,
  input  logic          arst_n,
  rd_req_if.reader      rd_req,
  wb_if.sink            wb,
  output rf_pkg::xlen_t csr_rdata
);

  rf_pkg::xlen_t mtvec;
  rf_pkg::xlen_t mepc;
  rf_pkg::xlen_t mstatus;
  rf_pkg::xlen_t mcause;

  rf_pkg::xlen_t mstatus_mret;
  rf_pkg::xlen_t csr_sel;

  logic          do_ecall;
  logic          do_mret;
  logic          do_write;
  logic          mtvec_we;
  logic          mepc_we;
  logic          mstatus_we;
  logic          mcause_we;

  // ========================================
  // update selection
  // ========================================
  // ecall wins over mret, both win over an explicit write.
  assign do_ecall = wb.valid && wb.ecall;
  assign do_mret  = wb.valid && wb.mret && !wb.ecall;
  assign do_write = wb.valid && wb.csr_wen && !wb.ecall && !wb.mret;

  // identity and unknown addresses get no enable.
  assign mtvec_we   = do_write && (wb.csr_addr == `CSR_MTVEC);
  assign mepc_we    = do_write && (wb.csr_addr == `CSR_MEPC);
  assign mstatus_we = do_write && (wb.csr_addr == `CSR_MSTATUS);
  assign mcause_we  = do_write && (wb.csr_addr == `CSR_MCAUSE);

  always_comb begin
    mstatus_mret                          = mstatus;
    mstatus_mret[`MSTATUS_MIE]            = mstatus[`MSTATUS_MPIE];
    mstatus_mret[`MSTATUS_MPIE]           = 1'b1;
    mstatus_mret[`MSTATUS_MPP_LO +: 2]    = 2'b00;  // back to least privilege.
  end

  // ========================================
  // csr registers
  // ========================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec <= '0;
    end else if (mtvec_we) begin
      mtvec <= wb.csr_wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mepc <= '0;
    end else if (do_ecall) begin
      mepc <= wb.pc;                // address of the ecall itself.
    end else if (mepc_we) begin
      mepc <= wb.csr_wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcause <= '0;
    end else if (do_ecall) begin
      mcause <= `ECALL_CAUSE;
    end else if (mcause_we) begin
      mcause <= wb.csr_wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mstatus <= `MSTATUS_RESET;
    end else if (do_ecall) begin
      mstatus <= `MSTATUS_RESET;
    end else if (do_mret) begin
      mstatus <= mstatus_mret;
    end else if (mstatus_we) begin
      mstatus <= wb.csr_wdata;
    end
  end

  // ========================================
  // read side
  // ========================================
  always_comb begin
    case (rd_req.csr_addr)
      `CSR_MSTATUS:   csr_sel = mstatus;
      `CSR_MTVEC:     csr_sel = mtvec;
      `CSR_MEPC:      csr_sel = mepc;
      `CSR_MCAUSE:    csr_sel = mcause;
      `CSR_MVENDORID: csr_sel = `MVENDORID_VAL;
      `CSR_MARCHID:   csr_sel = `MARCHID_VAL;
      default:        csr_sel = '0;
    endcase
  end

  // trap instructions need their target, not the addressed csr.
  assign csr_rdata = rd_req.inst_ecall ? mtvec :
                     rd_req.inst_mret  ? mepc  :
                     csr_sel;

endmodule

// File: hw/gpr_file.sv
`include "rf_consts.svh"

module gpr_file (
  input  logic          clk,
  input  logic          arst_n,
  rd_req_if.reader      rd_req,
  wb_if.sink            wb,
  output rf_pkg::xlen_t rdata1,
  output rf_pkg::xlen_t rdata2
);

  localparam int IDX_W = $clog2(`RF_NUM_REGS);

  rf_pkg::xlen_t regs [`RF_NUM_REGS];
  logic          wr_en;

  // x0 is never written, indices past x15 do not exist in rv32e.
  assign wr_en = wb.valid && wb.gpr_wen && (wb.rd != '0) && (wb.rd < `RF_NUM_REGS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd[IDX_W-1:0]] <= wb.gpr_wdata;
    end
  end

  // ========================================
  // read ports
  // ========================================
  function automatic rf_pkg::xlen_t read_reg(input rf_pkg::reg_idx_t idx);
    rf_pkg::xlen_t val;
    val = '0;
    if ((idx != '0) && (idx < `RF_NUM_REGS)) begin
      val = regs[idx[IDX_W-1:0]];
    end
    return val;
  endfunction

  always_comb begin
    rdata1 = read_reg(rd_req.rs1);  // old value on a same-edge write.
    rdata2 = read_reg(rd_req.rs2);
  end

endmodule

// File: hw/operand_stage.sv
module operand_stage (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          idu_valid,
  input  logic          exu_ready,
  input  rf_pkg::xlen_t gpr_rdata1,
  input  rf_pkg::xlen_t gpr_rdata2,
  input  rf_pkg::xlen_t csr_rdata,
  output logic          gpr_ready,
  output logic          gpr_valid,
  output rf_pkg::xlen_t src1,
  output rf_pkg::xlen_t src2,
  output rf_pkg::xlen_t csr_data
);

  rf_pkg::stage_state_e state;
  rf_pkg::stage_state_e next_state;
  logic                 capture;
  logic                 release_op;

  assign capture    = (state == rf_pkg::IDLE) && idu_valid;
  assign release_op = (state == rf_pkg::BUSY) && exu_ready;

  // ========================================
  // state machine
  // ========================================
  always_comb begin
    next_state = state;
    case (state)
      rf_pkg::IDLE: begin
        if (capture) begin
          next_state = rf_pkg::BUSY;
        end
      end
      rf_pkg::BUSY: begin
        if (release_op) begin
          next_state = rf_pkg::IDLE;
        end
      end
      default: next_state = rf_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rf_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ========================================
  // operand registers
  // ========================================
  // sampled before any writeback landing on the same edge.
  always_ff @(posedge clk) begin
    if (capture) begin
      src1     <= gpr_rdata1;
      src2     <= gpr_rdata2;
      csr_data <= csr_rdata;
    end
  end

  assign gpr_ready = (state == rf_pkg::IDLE);
  assign gpr_valid = (state == rf_pkg::BUSY);  // held until execute takes it.

endmodule

// File: hw/rf_consts.svh
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// ========================================
// register file geometry
// ========================================
`define RF_NUM_REGS     16            // rv32e general registers.

// ========================================
// machine-mode csr addresses
// ========================================
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12

// reset and fixed values
`define MSTATUS_RESET   32'h0000_1800 // mpp = machine, also the ecall value.
`define MVENDORID_VAL   32'h7973_7978
`define MARCHID_VAL     32'h017D_C685
`define ECALL_CAUSE     32'd11        // environment call from m-mode.

// mstatus fields
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MSTATUS_MPP_LO  11            // mpp is two bits wide.

`endif

// File: hw/rf_if.sv
// ========================================
// decode side read request
// ========================================
interface rd_req_if;

  rf_pkg::reg_idx_t  rs1;
  rf_pkg::reg_idx_t  rs2;
  rf_pkg::csr_addr_t csr_addr;
  logic              inst_ecall;   // read mtvec for the trap target.
  logic              inst_mret;    // read mepc for the return target.

  modport reader (
    input rs1,
    input rs2,
    input csr_addr,
    input inst_ecall,
    input inst_mret
  );

endinterface

// ========================================
// writeback strobe
// ========================================
interface wb_if;

  logic              valid;        // single-cycle strobe.
  rf_pkg::xlen_t     pc;
  rf_pkg::reg_idx_t  rd;
  logic              gpr_wen;
  rf_pkg::xlen_t     gpr_wdata;
  logic              csr_wen;
  rf_pkg::csr_addr_t csr_addr;
  rf_pkg::xlen_t     csr_wdata;
  logic              ecall;
  logic              mret;

  modport sink (
    input valid,
    input pc,
    input rd,
    input gpr_wen,
    input gpr_wdata,
    input csr_wen,
    input csr_addr,
    input csr_wdata,
    input ecall,
    input mret
  );

endinterface

// File: hw/rf_pkg.sv
package rf_pkg;

  // ========================================
  // data and index widths
  // ========================================
  typedef logic [31:0] xlen_t;      // one data word.
  typedef logic [4:0]  reg_idx_t;   // register field of the instruction.
  typedef logic [11:0] csr_addr_t;  // csr field of the instruction.

  // ========================================
  // operand stage control
  // ========================================
  typedef enum logic {
    IDLE = 1'b0,                    // waiting for a decode request.
    BUSY = 1'b1                     // operands held for execute.
  } stage_state_e;

endpackage

// File: hw/rf_top.sv
module rf_top (
  input  logic              clk,
  input  logic              arst_n,

  // decode side
  input  logic              idu_valid,
  input  rf_pkg::reg_idx_t  rs1,
  input  rf_pkg::reg_idx_t  rs2,
  input  rf_pkg::csr_addr_t csr_addr,
  input  logic              inst_ecall,
  input  logic              inst_mret,

  // execute side
  input  logic              exu_ready,

  // writeback side
  input  logic              wbu_valid,
  input  rf_pkg::xlen_t     wb_pc,
  input  rf_pkg::reg_idx_t  wb_rd,
  input  logic              wb_gpr_wen,
  input  rf_pkg::xlen_t     wb_gpr_wdata,
  input  logic              wb_csr_wen,
  input  rf_pkg::csr_addr_t wb_csr_addr,
  input  rf_pkg::xlen_t     wb_csr_wdata,
  input  logic              wb_ecall,
  input  logic              wb_mret,

  output logic              gpr_ready,
  output logic              gpr_valid,
  output rf_pkg::xlen_t     src1,
  output rf_pkg::xlen_t     src2,
  output rf_pkg::xlen_t     csr_data
);

  rf_pkg::xlen_t gpr_rdata1;
  rf_pkg::xlen_t gpr_rdata2;
  rf_pkg::xlen_t csr_rdata;

  // ========================================
  // interface bundles
  // ========================================
  rd_req_if rd_req ();
  wb_if     wb ();

  assign rd_req.rs1        = rs1;
  assign rd_req.rs2        = rs2;
  assign rd_req.csr_addr   = csr_addr;
  assign rd_req.inst_ecall = inst_ecall;
  assign rd_req.inst_mret  = inst_mret;

  assign wb.valid     = wbu_valid;
  assign wb.pc        = wb_pc;
  assign wb.rd        = wb_rd;
  assign wb.gpr_wen   = wb_gpr_wen;
  assign wb.gpr_wdata = wb_gpr_wdata;
  assign wb.csr_wen   = wb_csr_wen;
  assign wb.csr_addr  = wb_csr_addr;
  assign wb.csr_wdata = wb_csr_wdata;
  assign wb.ecall     = wb_ecall;
  assign wb.mret      = wb_mret;

  // ========================================
  // storage and stage
  // ========================================
  gpr_file u_gpr_file (
    .clk    (clk),
    .arst_n (arst_n),
    .rd_req (rd_req.reader),
    .wb     (wb.sink),
    .rdata1 (gpr_rdata1),
    .rdata2 (gpr_rdata2)
  );

  csr_file u_csr_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_req    (rd_req.reader),
    .wb        (wb.sink),
    .csr_rdata (csr_rdata)
  );

  operand_stage u_operand_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .idu_valid  (idu_valid),
    .exu_ready  (exu_ready),
    .gpr_rdata1 (gpr_rdata1),
    .gpr_rdata2 (gpr_rdata2),
    .csr_rdata  (csr_rdata),
    .gpr_ready  (gpr_ready),
    .gpr_valid  (gpr_valid),
    .src1       (src1),
    .src2       (src2),
    .csr_data   (csr_data)
  );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module rf_tb -o rf_sim

# a nonzero exit from the simulator counts as a failed run
./obj_dir/rf_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verification/rf_assertions.sv
module rf_assertions (
  input logic          clk,
  input logic          arst_n,
  input logic          exu_ready,
  input logic          gpr_ready,
  input logic          gpr_valid,
  input rf_pkg::xlen_t src1,
  input rf_pkg::xlen_t src2,
  input rf_pkg::xlen_t csr_data
);

  int fail_count = 0;               // failed assertion count.

  // ========================================
  // handshake properties
  // ========================================
  property ready_valid_exclusive;
    @(posedge clk) disable iff (!arst_n) !(gpr_ready && gpr_valid);
  endproperty

  property hold_under_stall;
    @(posedge clk) disable iff (!arst_n)
      (gpr_valid && !exu_ready) |=>
        (gpr_valid && $stable(src1) && $stable(src2) && $stable(csr_data));
  endproperty

  property idle_in_reset;
    @(posedge clk) !arst_n |-> !gpr_valid;
  endproperty

  a_exclusive: assert property (ready_valid_exclusive) else begin
    fail_count++;
    $error("ready and valid both high");
  end

  a_hold: assert property (hold_under_stall) else begin
    fail_count++;
    $error("operands moved under stall");
  end

  a_reset: assert property (idle_in_reset) else begin
    fail_count++;
    $error("gpr_valid high during reset");
  end

endmodule

// File: verification/rf_checker.sv
`include "rf_consts.svh"

module rf_checker (
  input logic              clk,
  input logic              arst_n,
  input logic              idu_valid,
  input rf_pkg::reg_idx_t  rs1,
  input rf_pkg::reg_idx_t  rs2,
  input rf_pkg::csr_addr_t csr_addr,
  input logic              inst_ecall,
  input logic              inst_mret,
  input logic              exu_ready,
  input logic              wbu_valid,
  input rf_pkg::xlen_t     wb_pc,
  input rf_pkg::reg_idx_t  wb_rd,
  input logic              wb_gpr_wen,
  input rf_pkg::xlen_t     wb_gpr_wdata,
  input logic              wb_csr_wen,
  input rf_pkg::csr_addr_t wb_csr_addr,
  input rf_pkg::xlen_t     wb_csr_wdata,
  input logic              wb_ecall,
  input logic              wb_mret,
  input logic              gpr_ready,
  input logic              gpr_valid,
  input rf_pkg::xlen_t     src1,
  input rf_pkg::xlen_t     src2,
  input rf_pkg::xlen_t     csr_data
);

  rf_pkg::xlen_t gregs [`RF_NUM_REGS];
  rf_pkg::xlen_t m_mtvec;
  rf_pkg::xlen_t m_mepc;
  rf_pkg::xlen_t m_mstatus;
  rf_pkg::xlen_t m_mcause;
  logic          busy;              // model of the stage state.
  logic [95:0]   exp_ops;           // {src1, src2, csr_data}.
  int            err_count = 0;
  int            check_count = 0;

  // ========================================
  // reference read
  // ========================================
  function automatic rf_pkg::xlen_t ref_gpr(input rf_pkg::reg_idx_t idx);
    if (idx == 5'd0 || int'(idx) >= `RF_NUM_REGS) return 32'd0;
    return gregs[idx[3:0]];
  endfunction

  function automatic logic [95:0] ref_operands(input rf_pkg::reg_idx_t r1,
                                               input rf_pkg::reg_idx_t r2,
                                               input rf_pkg::csr_addr_t a,
                                               input logic ec,
                                               input logic mr);
    rf_pkg::xlen_t c;
    if (ec) c = m_mtvec;
    else if (mr) c = m_mepc;
    else begin
      case (a)
        `CSR_MSTATUS:   c = m_mstatus;
        `CSR_MTVEC:     c = m_mtvec;
        `CSR_MEPC:      c = m_mepc;
        `CSR_MCAUSE:    c = m_mcause;
        `CSR_MVENDORID: c = `MVENDORID_VAL;
        `CSR_MARCHID:   c = `MARCHID_VAL;
        default:        c = 32'd0;
      endcase
    end
    return {ref_gpr(r1), ref_gpr(r2), c};
  endfunction

  task automatic check_value(input string name, input rf_pkg::xlen_t exp,
                             input rf_pkg::xlen_t act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // ========================================
  // compare and model update
  // ========================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        gregs[i] = 32'd0;
      end
      m_mtvec   = 32'd0;
      m_mepc    = 32'd0;
      m_mcause  = 32'd0;
      m_mstatus = `MSTATUS_RESET;
      busy      = 1'b0;
    end else begin
      check_value("gpr_valid", {31'd0, busy}, {31'd0, gpr_valid});
      check_value("gpr_ready", {31'd0, !busy}, {31'd0, gpr_ready});
      if (busy && exu_ready) begin
        check_value("src1", exp_ops[95:64], src1);
        check_value("src2", exp_ops[63:32], src2);
        check_value("csr_data", exp_ops[31:0], csr_data);
        busy = 1'b0;
      end else if (!busy && idu_valid) begin
        exp_ops = ref_operands(rs1, rs2, csr_addr, inst_ecall, inst_mret);  // pre-write state.
        busy    = 1'b1;
      end
      if (wbu_valid) begin
        if (wb_gpr_wen && wb_rd != 5'd0 && int'(wb_rd) < `RF_NUM_REGS) begin
          gregs[wb_rd[3:0]] = wb_gpr_wdata;
        end
        if (wb_ecall) begin
          m_mepc    = wb_pc;
          m_mcause  = `ECALL_CAUSE;
          m_mstatus = `MSTATUS_RESET;
        end else if (wb_mret) begin
          m_mstatus[`MSTATUS_MIE]           = m_mstatus[`MSTATUS_MPIE];
          m_mstatus[`MSTATUS_MPIE]          = 1'b1;
          m_mstatus[`MSTATUS_MPP_LO +: 2]   = 2'b00;
        end else if (wb_csr_wen) begin
          case (wb_csr_addr)
            `CSR_MSTATUS: m_mstatus = wb_csr_wdata;
            `CSR_MTVEC:   m_mtvec   = wb_csr_wdata;
            `CSR_MEPC:    m_mepc    = wb_csr_wdata;
            `CSR_MCAUSE:  m_mcause  = wb_csr_wdata;
            default: ;                  // read-only or unknown.
          endcase
        end
      end
    end
  end

endmodule

// File: verification/rf_tb.sv
`include "rf_consts.svh"

module rf_tb;

  logic              clk;
  logic              arst_n;
  logic              idu_valid;
  rf_pkg::reg_idx_t  rs1;
  rf_pkg::reg_idx_t  rs2;
  rf_pkg::csr_addr_t csr_addr;
  logic              inst_ecall;
  logic              inst_mret;
  logic              exu_ready;
  logic              wbu_valid;
  rf_pkg::xlen_t     wb_pc;
  rf_pkg::reg_idx_t  wb_rd;
  logic              wb_gpr_wen;
  rf_pkg::xlen_t     wb_gpr_wdata;
  logic              wb_csr_wen;
  rf_pkg::csr_addr_t wb_csr_addr;
  rf_pkg::xlen_t     wb_csr_wdata;
  logic              wb_ecall;
  logic              wb_mret;
  logic              gpr_ready;
  logic              gpr_valid;
  rf_pkg::xlen_t     src1;
  rf_pkg::xlen_t     src2;
  rf_pkg::xlen_t     csr_data;

  integer            seed;
  int                tests;
  int                err_base;
  int                n;
  rf_pkg::csr_addr_t csr_list [7];

  rf_top     u_rf_top (.*);
  rf_checker u_checker (.*);

  bind operand_stage rf_assertions u_assertions (
    .clk(clk), .arst_n(arst_n), .exu_ready(exu_ready), .gpr_ready(gpr_ready),
    .gpr_valid(gpr_valid), .src1(src1), .src2(src2), .csr_data(csr_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================
  // stimulus tasks
  // ========================================
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_ready();
    int t;
    t = 0;
    while (!gpr_ready && t <= 50) begin
      step();
      t++;
    end
    if (!gpr_ready) begin
      $display("timeout: gpr_ready did not return after a request");
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic set_wb(input rf_pkg::xlen_t pc, input rf_pkg::reg_idx_t rd, input logic gwen,
                        input rf_pkg::xlen_t gd, input logic cwen, input rf_pkg::csr_addr_t ca,
                        input rf_pkg::xlen_t cd, input logic ec, input logic mr);
    wbu_valid    = 1'b1;
    wb_pc        = pc;
    wb_rd        = rd;
    wb_gpr_wen   = gwen;
    wb_gpr_wdata = gd;
    wb_csr_wen   = cwen;
    wb_csr_addr  = ca;
    wb_csr_wdata = cd;
    wb_ecall     = ec;
    wb_mret      = mr;
  endtask

  task automatic write_back(input rf_pkg::xlen_t pc, input rf_pkg::reg_idx_t rd, input logic gwen,
                            input rf_pkg::xlen_t gd, input logic cwen, input rf_pkg::csr_addr_t ca,
                            input rf_pkg::xlen_t cd, input logic ec, input logic mr);
    set_wb(pc, rd, gwen, gd, cwen, ca, cd, ec, mr);
    step();
    wbu_valid = 1'b0;
  endtask

  // a writeback set up before the call lands on the capturing edge.
  task automatic request(input rf_pkg::reg_idx_t r1, input rf_pkg::reg_idx_t r2,
                         input rf_pkg::csr_addr_t a, input logic ec, input logic mr);
    wait_ready();
    rs1        = r1;
    rs2        = r2;
    csr_addr   = a;
    inst_ecall = ec;
    inst_mret  = mr;
    idu_valid  = 1'b1;
    exu_ready  = 1'b1;
    step();
    idu_valid  = 1'b0;
    wbu_valid  = 1'b0;
    wait_ready();
  endtask

  function automatic int error_total();
    return u_checker.err_count + u_rf_top.u_operand_stage.u_assertions.fail_count;
  endfunction

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (error_total() == err_base) ? "ok" : "failed");
    err_base = error_total();
  endtask

  function automatic rf_pkg::reg_idx_t rand_idx();
    return rf_pkg::reg_idx_t'($random(seed));
  endfunction

  // ========================================
  // test sequence
  // ========================================
  initial begin
    seed = 96;
    tests = 0;
    err_base = 0;
    csr_list = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE,
                 `CSR_MVENDORID, `CSR_MARCHID, 12'h123};
    arst_n = 1'b1;
    idu_valid = 1'b0;
    rs1 = '0;
    rs2 = '0;
    csr_addr = '0;
    inst_ecall = 1'b0;
    inst_mret = 1'b0;
    exu_ready = 1'b0;
    set_wb('0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
    wbu_valid = 1'b0;
    #5 arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #10 arst_n = 1'b1;
    step();

    for (int i = 0; i < 16; i++) begin
      request(5'(i), 5'(15 - i), csr_list[i % 7], 1'b0, 1'b0);
    end
    finish_test("reset values");

    for (int i = 0; i < 30; i++) begin
      write_back('0, rand_idx(), 1'b1, $random(seed), 1'b0, '0, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 20; i++) begin
      request(rand_idx(), rand_idx(), '0, 1'b0, 1'b0);
    end
    write_back('0, 5'd0, 1'b1, 32'hDEAD_BEEF, 1'b0, '0, '0, 1'b0, 1'b0);
    write_back('0, 5'd17, 1'b1, 32'h1234_5678, 1'b0, '0, '0, 1'b0, 1'b0);
    request(5'd0, 5'd1, '0, 1'b0, 1'b0);    // x17 must not alias onto x1.
    request(5'd17, 5'd31, '0, 1'b0, 1'b0);
    set_wb('0, 5'd5, 1'b1, 32'hA5A5_5A5A, 1'b0, '0, '0, 1'b0, 1'b0);
    request(5'd5, 5'd0, '0, 1'b0, 1'b0);   // same-edge write stays hidden.
    request(5'd5, 5'd5, '0, 1'b0, 1'b0);
    finish_test("register traffic");

    for (int i = 0; i < 7; i++) begin
      write_back('0, '0, 1'b0, '0, 1'b1, csr_list[i], $random(seed), 1'b0, 1'b0);
      for (int j = 0; j < 7; j++) begin
        request(rand_idx(), rand_idx(), csr_list[j], 1'b0, 1'b0);
      end
    end
    finish_test("csr writes");

    write_back('0, '0, 1'b0, '0, 1'b1, `CSR_MTVEC, $random(seed), 1'b0, 1'b0);
    write_back($random(seed), '0, 1'b0, '0, 1'b1, `CSR_MEPC, 32'hFFFF, 1'b1, 1'b1);
    request('0, '0, '0, 1'b1, 1'b0);
    for (int j = 0; j < 4; j++) begin
      request('0, '0, csr_list[j], 1'b0, 1'b0);
    end
    write_back('0, '0, 1'b0, '0, 1'b1, `CSR_MSTATUS, '0, 1'b0, 1'b1);
    request('0, '0, '0, 1'b0, 1'b1);
    request('0, '0, `CSR_MSTATUS, 1'b0, 1'b0);
    write_back('0, '0, 1'b0, '0, 1'b1, `CSR_MSTATUS, 32'h0000_1880, 1'b0, 1'b0);
    write_back('0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b1);
    request('0, '0, `CSR_MSTATUS, 1'b0, 1'b0);
    finish_test("traps");

    for (int i = 0; i < 6; i++) begin
      wait_ready();
      rs1 = rand_idx();
      rs2 = rand_idx();
      csr_addr = `CSR_MTVEC;
      idu_valid = 1'b1;
      exu_ready = 1'b0;
      step();
      n = ($random(seed) & 7) + 2;
      for (int k = 0; k < n; k++) begin
        idu_valid = 1'($random(seed));   // pulses the stage must ignore.
        rs1 = rand_idx();
        set_wb('0, rand_idx(), 1'b1, $random(seed), 1'b1, `CSR_MTVEC, $random(seed), 1'b0, 1'b0);
        step();
        wbu_valid = 1'b0;
      end
      idu_valid = 1'b0;
      exu_ready = 1'b1;
      wait_ready();
    end
    finish_test("back-pressure");

    $display("tests %0d, checks %0d, errors %0d",
             tests, u_checker.check_count, error_total());
    if (error_total() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
